// File: flist.f
src/isaPkg.sv
src/ooPkg.sv
src/regStatusFile.sv
src/loadStation.sv
src/loadMemPort.sv
src/loadUnit.sv
testbench/wbMemModel.sv
testbench/loadUnit_props.sv
testbench/loadUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module loadUnitTb -o loadUnitSim

status=0
./obj_dir/loadUnitSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Some tests failed" sim.log; then
    echo "Some tests failed"
    exit 1
fi

// File: src/isaPkg.sv
package isaPkg;

    localparam int opcodeWidth = 6;
    localparam int regIndexWidth = 5;
    localparam int immWidth = 16;
    localparam int padWidth = 11;

    localparam logic [opcodeWidth-1:0] opLw = 6'h23;
    localparam logic [opcodeWidth-1:0] opLwrr = 6'h25;

    // immediate form, base rj plus sign-extended imm
    typedef struct packed {
        logic [opcodeWidth-1:0]   opcode;
        logic [regIndexWidth-1:0] rj;
        logic [regIndexWidth-1:0] rd;
        logic [immWidth-1:0]      imm;
    } immWord;

    // register-register form, base rj plus rk
    typedef struct packed {
        logic [opcodeWidth-1:0]   opcode;
        logic [regIndexWidth-1:0] rj;
        logic [regIndexWidth-1:0] rd;
        logic [regIndexWidth-1:0] rk;
        logic [padWidth-1:0]      pad;
    } rrWord;

    // opcode picks the view, both share opcode, rj and rd positions
    typedef union packed {
        immWord immView;
        rrWord  rrView;
    } instWord;

endpackage

// File: src/loadMemPort.sv
`timescale 1ns/1ps

module loadMemPort (
    input  logic                        clk,
    input  logic                        reset,
    input  ooPkg::memReqT               memReq [ooPkg::stationCount],
    output ooPkg::wbAdrT                wbAdr,
    output logic                        wbCyc,
    output logic                        wbStb,
    output logic                        wbWe,
    output ooPkg::wbSelT                wbSel,
    input  logic [ooPkg::wordWidth-1:0] wbDatI,
    input  logic                        wbAck,
    output ooPkg::cdbT                  cdbOut
);

    localparam int ptrWidth = $clog2(ooPkg::stationCount);

    typedef enum logic [1:0] {
        stIdle,
        stBus,
        stBroadcast
    } stateT;

    stateT state;
    logic [ptrWidth-1:0] rrPtr;
    logic [ptrWidth-1:0] pick;
    logic pickValid;

    ooPkg::tagT grantTag;
    ooPkg::wbAdrT grantAdr;
    logic [ooPkg::wordWidth-1:0] readData;

    // first ready station at or after the pointer
    always_comb begin
        logic [ptrWidth-1:0] idx;
        pickValid = 1'b0;
        pick = rrPtr;
        for (int i = 0; i < ooPkg::stationCount; i++) begin
            idx = ptrWidth'((int'(rrPtr) + i) % ooPkg::stationCount);
            if (!pickValid && memReq[idx].ready) begin
                pickValid = 1'b1;
                pick = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stIdle;
            rrPtr <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (pickValid) begin
                        state <= stBus;
                        rrPtr <= pick + 1'b1;
                    end
                end
                stBus: begin
                    if (wbAck) begin
                        state <= stBroadcast;
                    end
                end
                stBroadcast: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && pickValid) begin
            grantTag <= ooPkg::tagT'(pick) + ooPkg::tagT'(1);
            grantAdr <= memReq[pick].addr;
        end
        if (state == stBus && wbAck) begin
            readData <= wbDatI;
        end
    end

    // classic cycle, read only, full word
    assign wbCyc = state == stBus;
    assign wbStb = state == stBus;
    assign wbWe = 1'b0;
    assign wbSel = '1;
    assign wbAdr = grantAdr;

    always_comb begin
        cdbOut.valid = state == stBroadcast;
        cdbOut.tag = grantTag;
        cdbOut.data = readData;
    end

endmodule

// File: src/loadStation.sv
`timescale 1ns/1ps

module loadStation (
    input  logic           clk,
    input  logic           reset,
    input  ooPkg::tagT     myTag,
    input  logic           load,
    input  ooPkg::issueT   issueIn,
    input  ooPkg::operandT srcJ,
    input  ooPkg::operandT srcK,
    input  ooPkg::cdbT     cdbIn,
    output logic           busy,
    output ooPkg::memReqT  memReq
);

    ooPkg::tagT tagJ;
    ooPkg::tagT tagK;
    logic [ooPkg::wordWidth-1:0] valueJ;
    logic [ooPkg::wordWidth-1:0] valueK;

    logic isImm;
    logic [ooPkg::wordWidth-1:0] immExt;
    logic hitJ;
    logic hitK;
    logic ownBroadcast;

    assign isImm = issueIn.inst.immView.opcode == isaPkg::opLw;

    assign immExt = {
        {(ooPkg::wordWidth - isaPkg::immWidth){issueIn.inst.immView.imm[isaPkg::immWidth-1]}},
        issueIn.inst.immView.imm
    };

    // pending operand picks up a matching broadcast
    assign hitJ = busy && cdbIn.valid && tagJ != ooPkg::tagReady && tagJ == cdbIn.tag;
    assign hitK = busy && cdbIn.valid && tagK != ooPkg::tagReady && tagK == cdbIn.tag;

    // our own result going out means the load is done
    assign ownBroadcast = busy && cdbIn.valid && cdbIn.tag == myTag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            tagJ <= ooPkg::tagReady;
            tagK <= ooPkg::tagReady;
        end else begin
            if (load) begin
                busy <= 1'b1;
                tagJ <= srcJ.tag;
                if (isImm) begin
                    tagK <= ooPkg::tagReady;
                end else begin
                    tagK <= srcK.tag;
                end
            end else begin
                if (ownBroadcast) begin
                    busy <= 1'b0;
                end
                if (hitJ) begin
                    tagJ <= ooPkg::tagReady;
                end
                if (hitK) begin
                    tagK <= ooPkg::tagReady;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            valueJ <= srcJ.value;
            if (isImm) begin
                valueK <= immExt;
            end else begin
                valueK <= srcK.value;
            end
        end else begin
            if (hitJ) begin
                valueJ <= cdbIn.data;
            end
            if (hitK) begin
                valueK <= cdbIn.data;
            end
        end
    end

    // address is valid the cycle after both tags clear
    always_comb begin
        memReq.addr = valueJ + valueK;
        memReq.ready = busy && tagJ == ooPkg::tagReady && tagK == ooPkg::tagReady;
    end

endmodule

// File: src/loadUnit.sv
`timescale 1ns/1ps

module loadUnit (
    input  logic                        clk,
    input  logic                        reset,
    input  ooPkg::issueT                issueIn,
    output logic                        issueReady,
    input  ooPkg::regWriteT             regWriteIn,
    output ooPkg::wbAdrT                wbAdr,
    output logic                        wbCyc,
    output logic                        wbStb,
    output logic                        wbWe,
    output ooPkg::wbSelT                wbSel,
    input  logic [ooPkg::wordWidth-1:0] wbDatI,
    input  logic                        wbAck,
    output ooPkg::cdbT                  cdbOut
);

    logic [ooPkg::stationCount-1:0] stationBusy;
    logic [ooPkg::stationCount-1:0] stationLoad;
    logic [ooPkg::stationCount:0] freeSeen;
    logic issueFire;
    ooPkg::tagT issueTag;
    ooPkg::operandT srcJ;
    ooPkg::operandT srcK;
    ooPkg::memReqT memReq [ooPkg::stationCount];
    ooPkg::cdbT cdbBus;

    // lowest free station takes the instruction
    assign freeSeen[0] = 1'b0;
    assign issueReady = freeSeen[ooPkg::stationCount];
    assign issueFire = issueIn.valid && issueReady;

    always_comb begin
        issueTag = ooPkg::tagReady;
        for (int i = ooPkg::stationCount - 1; i >= 0; i--) begin
            if (!stationBusy[i]) begin
                issueTag = ooPkg::tagT'(i + 1);
            end
        end
    end

    assign cdbOut = cdbBus;

    regStatusFile u_regStatusFile (
        .clk        (clk),
        .reset      (reset),
        .issueIn    (issueIn),
        .issueFire  (issueFire),
        .issueTag   (issueTag),
        .cdbIn      (cdbBus),
        .regWriteIn (regWriteIn),
        .srcJ       (srcJ),
        .srcK       (srcK)
    );

    for (genvar i = 0; i < ooPkg::stationCount; i++) begin : g_station
        assign freeSeen[i+1] = freeSeen[i] | ~stationBusy[i];
        assign stationLoad[i] = issueFire && !stationBusy[i] && !freeSeen[i];

        loadStation u_loadStation (
            .clk     (clk),
            .reset   (reset),
            .myTag   (ooPkg::tagT'(i + 1)),
            .load    (stationLoad[i]),
            .issueIn (issueIn),
            .srcJ    (srcJ),
            .srcK    (srcK),
            .cdbIn   (cdbBus),
            .busy    (stationBusy[i]),
            .memReq  (memReq[i])
        );
    end

    loadMemPort u_loadMemPort (
        .clk    (clk),
        .reset  (reset),
        .memReq (memReq),
        .wbAdr  (wbAdr),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbSel  (wbSel),
        .wbDatI (wbDatI),
        .wbAck  (wbAck),
        .cdbOut (cdbBus)
    );

endmodule

// File: src/ooPkg.sv
package ooPkg;

    localparam int wordWidth = 32;
    localparam int stationCount = 4;
    localparam int tagWidth = 3;

    typedef logic [tagWidth-1:0] tagT;

    // tag 0 means the value is present
    localparam tagT tagReady = '0;

    typedef logic [wordWidth-1:0] wbAdrT;
    typedef logic [wordWidth/8-1:0] wbSelT;

    typedef struct packed {
        logic                 valid;
        tagT                  tag;
        logic [wordWidth-1:0] data;
    } cdbT;

    typedef struct packed {
        logic            valid;
        isaPkg::instWord inst;
    } issueT;

    typedef struct packed {
        tagT                  tag;
        logic [wordWidth-1:0] value;
    } operandT;

    typedef struct packed {
        logic                             valid;
        logic [isaPkg::regIndexWidth-1:0] regNum;
        logic [wordWidth-1:0]             data;
    } regWriteT;

    typedef struct packed {
        wbAdrT addr;
        logic  ready;
    } memReqT;

endpackage

// File: src/regStatusFile.sv
`timescale 1ns/1ps

module regStatusFile (
    input  logic            clk,
    input  logic            reset,
    input  ooPkg::issueT    issueIn,
    input  logic            issueFire,
    input  ooPkg::tagT      issueTag,
    input  ooPkg::cdbT      cdbIn,
    input  ooPkg::regWriteT regWriteIn,
    output ooPkg::operandT  srcJ,
    output ooPkg::operandT  srcK
);

    localparam int regCount = 2 ** isaPkg::regIndexWidth;

    logic [ooPkg::wordWidth-1:0] regValue [regCount];
    ooPkg::tagT regTag [regCount];

    logic [isaPkg::regIndexWidth-1:0] idxJ;
    logic [isaPkg::regIndexWidth-1:0] idxK;
    logic [isaPkg::regIndexWidth-1:0] idxD;

    // current value and tag of one register, with the broadcast forwarded
    function automatic ooPkg::operandT lookup(input logic [isaPkg::regIndexWidth-1:0] idx);
        ooPkg::operandT op;
        op.tag = regTag[idx];
        op.value = regValue[idx];
        if (idx == '0) begin
            op.tag = ooPkg::tagReady;
            op.value = '0;
        end else if (op.tag != ooPkg::tagReady && cdbIn.valid && cdbIn.tag == op.tag) begin
            op.tag = ooPkg::tagReady;
            op.value = cdbIn.data;
        end
        return op;
    endfunction

    always_comb begin
        idxJ = issueIn.inst.immView.rj;
        idxD = issueIn.inst.immView.rd;
        // immediate form has no rk, so read r0 which is always ready
        if (issueIn.inst.rrView.opcode == isaPkg::opLwrr) begin
            idxK = issueIn.inst.rrView.rk;
        end else begin
            idxK = '0;
        end
    end

    always_comb begin
        srcJ = lookup(idxJ);
        srcK = lookup(idxK);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regTag[i] <= ooPkg::tagReady;
            end
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (cdbIn.valid && regTag[i] != ooPkg::tagReady && regTag[i] == cdbIn.tag) begin
                    regTag[i] <= ooPkg::tagReady;
                end
            end
            if (regWriteIn.valid && regWriteIn.regNum != '0) begin
                regTag[regWriteIn.regNum] <= ooPkg::tagReady;
            end
            // a new rename overrides the retire above
            if (issueFire && idxD != '0) begin
                regTag[idxD] <= issueTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < regCount; i++) begin
            if (cdbIn.valid && regTag[i] != ooPkg::tagReady && regTag[i] == cdbIn.tag) begin
                regValue[i] <= cdbIn.data;
            end
        end
        if (regWriteIn.valid && regWriteIn.regNum != '0) begin
            regValue[regWriteIn.regNum] <= regWriteIn.data;
        end
    end

endmodule

// File: testbench/loadUnitTb.sv
`timescale 1ns/1ps

module loadUnitTb;

    localparam int clkPeriod = 4;
    localparam int tableLen = 13;
    localparam logic [ooPkg::wordWidth-1:0] dataPattern = 32'h5A5A_C3C3;

    typedef struct packed {
        isaPkg::instWord             inst;
        logic                        drain;
        logic                        mustStall;
        ooPkg::wbAdrT                expAdr;
        logic [ooPkg::wordWidth-1:0] expData;
    } stimT;

    logic clk;
    logic reset;
    ooPkg::issueT issueIn;
    logic issueReady;
    ooPkg::regWriteT regWriteIn;
    ooPkg::wbAdrT wbAdr;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    ooPkg::wbSelT wbSel;
    logic [ooPkg::wordWidth-1:0] wbDatI;
    logic wbAck;
    ooPkg::cdbT cdbOut;

    stimT stimTable [tableLen];
    logic [ooPkg::wordWidth-1:0] refReg [32];
    logic tbBusy [1:ooPkg::stationCount];
    int tagOwner [1:ooPkg::stationCount];
    int curEntry = 0;
    int outstanding = 0;
    ooPkg::wbAdrT lastAckAdr = '0;
    int errorCount = 0;
    int checkCount = 0;

    loadUnit u_loadUnit (
        .clk        (clk),
        .reset      (reset),
        .issueIn    (issueIn),
        .issueReady (issueReady),
        .regWriteIn (regWriteIn),
        .wbAdr      (wbAdr),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbSel      (wbSel),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .cdbOut     (cdbOut)
    );

    wbMemModel #(.dataPattern(dataPattern)) u_wbMemModel (
        .clk    (clk),
        .reset  (reset),
        .wbAdr  (wbAdr),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbDatO (wbDatI),
        .wbAck  (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkBit(input string name, input logic got, input logic want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic checkAdr(input string name, input ooPkg::wbAdrT got, input ooPkg::wbAdrT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic checkSel(input string name, input ooPkg::wbSelT got, input ooPkg::wbSelT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic checkCdb(input string name, input ooPkg::cdbT got, input ooPkg::cdbT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("[FAIL] %0t %s got %0b/%0d/%h expected %0b/%0d/%h", $time, name,
                got.valid, got.tag, got.data, want.valid, want.tag, want.data);
        end
    endtask

    function automatic isaPkg::instWord immLoad(input int rd, input int rj, input int imm);
        isaPkg::instWord w;
        w.immView.opcode = isaPkg::opLw;
        w.immView.rj = 5'(rj);
        w.immView.rd = 5'(rd);
        w.immView.imm = 16'(imm);
        return w;
    endfunction

    function automatic isaPkg::instWord rrLoad(input int rd, input int rj, input int rk);
        isaPkg::instWord w;
        w.rrView.opcode = isaPkg::opLwrr;
        w.rrView.rj = 5'(rj);
        w.rrView.rd = 5'(rd);
        w.rrView.rk = 5'(rk);
        w.rrView.pad = '0;
        return w;
    endfunction

    task automatic setEntry(input int idx, input isaPkg::instWord inst, input logic drain,
                            input logic mustStall);
        stimTable[idx] = '{inst: inst, drain: drain, mustStall: mustStall,
                           expAdr: '0, expData: '0};
    endtask

    task automatic preloadReg(input int regNum, input logic [ooPkg::wordWidth-1:0] value);
        regWriteIn <= '{valid: 1'b1, regNum: 5'(regNum), data: value};
        refReg[regNum] = value;
        @(posedge clk);
    endtask

    // reference register file walked in program order
    task automatic computeExpected();
        isaPkg::instWord w;
        logic [ooPkg::wordWidth-1:0] offset;
        for (int i = 0; i < tableLen; i++) begin
            w = stimTable[i].inst;
            if (w.rrView.opcode == isaPkg::opLwrr) begin
                offset = refReg[w.rrView.rk];
            end else begin
                offset = {{16{w.immView.imm[15]}}, w.immView.imm};
            end
            stimTable[i].expAdr = refReg[w.immView.rj] + offset;
            stimTable[i].expData = stimTable[i].expAdr ^ dataPattern;
            if (w.immView.rd != 5'd0) begin
                refReg[w.immView.rd] = stimTable[i].expData;
            end
        end
    endtask

    // called on a rising edge and returns on the edge that accepts the load
    task automatic issueOne(input int idx, output logic stalled);
        curEntry = idx;
        issueIn <= '{valid: 1'b1, inst: stimTable[idx].inst};
        stalled = 1'b0;
        @(negedge clk);
        while (!issueReady) begin
            stalled = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // shadow of station occupancy where the lowest free tag wins at issue
    always @(negedge clk) begin : monitor
        int tag;
        ooPkg::cdbT want;
        if (!reset) begin
            if (issueIn.valid && issueReady) begin
                tag = 0;
                for (int t = ooPkg::stationCount; t >= 1; t--) begin
                    if (!tbBusy[t]) begin
                        tag = t;
                    end
                end
                if (tag == 0) begin
                    errorCount++;
                    $display("issue accepted at %0t while every station was busy", $time);
                end else begin
                    tbBusy[tag] = 1'b1;
                    tagOwner[tag] = curEntry;
                    outstanding++;
                end
            end
            if (wbCyc && wbStb && wbAck) begin
                lastAckAdr = wbAdr;
                checkBit("wbWe", wbWe, 1'b0);
                checkSel("wbSel", wbSel, '1);
            end
            if (cdbOut.valid) begin
                tag = int'(cdbOut.tag);
                if (tag < 1 || tag > ooPkg::stationCount) begin
                    errorCount++;
                    $display("broadcast at %0t carries tag %0d outside the stations", $time, tag);
                end else if (!tbBusy[tag]) begin
                    errorCount++;
                    $display("broadcast at %0t for tag %0d with no load in flight", $time, tag);
                end else begin
                    want = '{valid: 1'b1, tag: ooPkg::tagT'(tag),
                             data: stimTable[tagOwner[tag]].expData};
                    checkCdb("cdbOut", cdbOut, want);
                    checkAdr("wbAdr", lastAckAdr, stimTable[tagOwner[tag]].expAdr);
                    tbBusy[tag] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    initial begin : stimulus
        logic stalled;
        reset = 1'b1;
        issueIn = '0;
        regWriteIn = '0;
        for (int t = 1; t <= ooPkg::stationCount; t++) begin
            tbBusy[t] = 1'b0;
            tagOwner[t] = 0;
        end
        for (int r = 0; r < 32; r++) begin
            refReg[r] = '0;
        end
        setEntry(0, immLoad(10, 1, 16), 1'b1, 1'b0);
        setEntry(1, immLoad(11, 2, -8), 1'b1, 1'b0);
        setEntry(2, rrLoad(12, 3, 4), 1'b1, 1'b0);
        // chained base through r13
        setEntry(3, immLoad(13, 1, 4), 1'b0, 1'b0);
        setEntry(4, immLoad(14, 13, 32), 1'b1, 1'b0);
        for (int i = 0; i < 5; i++) begin
            setEntry(5 + i, immLoad(15 + i, 5 + i, 0), i == 4, i == 4);
        end
        // r20 renamed twice before r21 reads it
        setEntry(10, immLoad(20, 1, 8), 1'b0, 1'b0);
        setEntry(11, immLoad(20, 2, 12), 1'b0, 1'b0);
        setEntry(12, immLoad(21, 20, 48), 1'b1, 1'b0);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkBit("issueReady", issueReady, 1'b1);
        checkBit("wbCyc", wbCyc, 1'b0);
        checkBit("wbStb", wbStb, 1'b0);
        checkBit("cdbOut.valid", cdbOut.valid, 1'b0);
        @(posedge clk);
        preloadReg(1, 32'h0000_1000);
        preloadReg(2, 32'h0000_2000);
        preloadReg(3, 32'h0000_3000);
        preloadReg(4, 32'h0000_0040);
        for (int r = 5; r < 10; r++) begin
            preloadReg(r, 32'h0000_5000 + 32'(r * 256));
        end
        regWriteIn <= '0;
        computeExpected();

        for (int i = 0; i < tableLen; i++) begin
            issueOne(i, stalled);
            if (stimTable[i].mustStall && !stalled) begin
                errorCount++;
                $display("issueReady stayed high for load %0d with four loads in flight", i);
            end
            if (stimTable[i].drain) begin
                issueIn <= '0;
                while (outstanding != 0) begin
                    @(negedge clk);
                end
                @(posedge clk);
            end
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(tableLen * 40 * clkPeriod);
        $display("timeout, %0d loads still in flight, errors: %0d", outstanding, errorCount);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: testbench/loadUnit_props.sv
`timescale 1ns/1ps

module loadUnit_props (
    input logic         clk,
    input logic         reset,
    input logic         wbCyc,
    input logic         wbStb,
    input logic         wbAck,
    input ooPkg::wbAdrT wbAdr,
    input ooPkg::cdbT   cdbOut,
    input ooPkg::issueT issueIn,
    input logic         issueReady
);

    logic [2:0] inFlight;

    // loads in flight as counted from accepted issues and broadcasts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + 3'(issueIn.valid && issueReady) - 3'(cdbOut.valid);
        end
    end

    stbNeedsCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    adrHeld: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> $stable(wbAdr))
        else $error("wbAdr changed while waiting for ack");

    cdbOneCycle: assert property (@(posedge clk) disable iff (reset)
        cdbOut.valid |=> !cdbOut.valid)
        else $error("cdbOut.valid high for two cycles");

    // back-pressure only with every station taken
    readyWhenFree: assert property (@(posedge clk) disable iff (reset)
        !issueReady |-> inFlight == 3'(ooPkg::stationCount))
        else $error("issueReady low with a free station");

endmodule

bind loadUnit loadUnit_props u_loadUnitProps (
    .clk        (clk),
    .reset      (reset),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbAck      (wbAck),
    .wbAdr      (wbAdr),
    .cdbOut     (cdbOut),
    .issueIn    (issueIn),
    .issueReady (issueReady)
);

// File: testbench/wbMemModel.sv
`timescale 1ns/1ps

module wbMemModel #(
    parameter logic [31:0] dataPattern = 32'h0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  ooPkg::wbAdrT                wbAdr,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    output logic [ooPkg::wordWidth-1:0] wbDatO,
    output logic                        wbAck
);

    integer seed = 3;
    logic active;
    logic [1:0] waitLeft;

    // read data is the address xor a fixed pattern, ack after 0 to 3 waits
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wbAck <= 1'b0;
            active <= 1'b0;
            waitLeft <= '0;
            wbDatO <= '0;
        end else begin
            wbAck <= 1'b0;
            if (wbCyc && wbStb && !wbAck) begin
                if (!active) begin
                    active <= 1'b1;
                    waitLeft <= 2'($random(seed));
                end else if (waitLeft == 2'd0) begin
                    active <= 1'b0;
                    wbAck <= 1'b1;
                    wbDatO <= wbAdr ^ dataPattern;
                end else begin
                    waitLeft <= waitLeft - 2'd1;
                end
            end
        end
    end

endmodule
